//--- design/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// General register file geometry
`define REG_COUNT   32
`define REG_ADDR_W  5

// PC, instruction and CSR data width
`define DATA_W      32

// Configuration port address width
`define CSR_ADDR_W  2

`endif

//--- design/isa_pkg.sv
`include "core_defines.svh"

package isa_pkg;

    typedef enum logic [3:0] {
        OP_ADDU    = 4'd0,
        OP_SUBU    = 4'd1,
        OP_AND     = 4'd2,
        OP_OR      = 4'd3,
        OP_SLL     = 4'd4,
        OP_ADDIU   = 4'd5,
        OP_ORI     = 4'd6,
        OP_LUI     = 4'd7,
        OP_LW      = 4'd8,
        OP_SW      = 4'd9,
        OP_BEQ     = 4'd10,
        OP_BNE     = 4'd11,
        OP_J       = 4'd12,
        OP_JR      = 4'd13,
        OP_ILLEGAL = 4'd15
    } op_e;

    // Decoded instruction as it travels from id1 to issue
    typedef struct packed {
        logic                   valid;
        op_e                    op;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     inst;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] sa;
        logic                   w_reg_ena;
        logic [`REG_ADDR_W-1:0] w_reg_dst;
        logic [15:0]            imme;
        logic [25:0]            j_imme;
        logic                   is_branch;      // BEQ / BNE
        logic                   is_jr;
        logic                   is_j_imme;
        logic                   is_ls;          // LW / SW
        logic                   in_delay_slot;
        logic                   illegal;
    } id_bundle_t;

endpackage

//--- design/pipe_pkg.sv
`include "core_defines.svh"

package pipe_pkg;

    // Instruction word from fetch
    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] inst;
    } fetch_t;

    // Completed register write from downstream
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] reg_idx;
    } wb_t;

    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     wdata;
    } cfg_req_t;

    typedef struct packed {
        logic               ack;
        logic [`DATA_W-1:0] rdata;
    } cfg_rsp_t;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CTRL    = 2'd0,
        CSR_ISSUED  = 2'd1,
        CSR_STALLS  = 2'd2,
        CSR_FLUSHES = 2'd3
    } csr_addr_e;

endpackage

//--- design/id1_decoder.sv
`include "core_defines.svh"

module id1_decoder (
    input  logic                clk,
    input  logic                rst_n_i,
    input  pipe_pkg::fetch_t    fetch_i,
    input  logic                accept_i,
    input  logic                flush_i,
    output isa_pkg::id_bundle_t bundle_o
);
    import isa_pkg::*;

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL      = 6'h00;
    localparam logic [5:0] FN_JR       = 6'h08;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;

    logic [5:0]             opc;
    logic [5:0]             funct;
    logic [`REG_ADDR_W-1:0] rd;
    op_e                    op;
    logic                   w_ena;
    logic [`REG_ADDR_W-1:0] w_dst;
    logic                   ctrl_xfer;
    logic                   delay_slot_q;

    assign opc   = fetch_i.inst[31:26];
    assign funct = fetch_i.inst[5:0];
    assign rd    = fetch_i.inst[15:11];

    always_comb begin
        op = OP_ILLEGAL;
        case (opc)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADDU: op = OP_ADDU;
                    FN_SUBU: op = OP_SUBU;
                    FN_AND:  op = OP_AND;
                    FN_OR:   op = OP_OR;
                    FN_SLL:  op = OP_SLL;
                    FN_JR:   op = OP_JR;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_ADDIU: op = OP_ADDIU;
            OPC_ORI:   op = OP_ORI;
            OPC_LUI:   op = OP_LUI;
            OPC_LW:    op = OP_LW;
            OPC_SW:    op = OP_SW;
            OPC_BEQ:   op = OP_BEQ;
            OPC_BNE:   op = OP_BNE;
            OPC_J:     op = OP_J;
            default:   op = OP_ILLEGAL;
        endcase
    end

    always_comb begin
        w_ena = 1'b0;
        w_dst = '0;
        case (op)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLL: begin
                w_ena = 1'b1;
                w_dst = rd;
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                w_ena = 1'b1;
                w_dst = fetch_i.inst[20:16];
            end
            default: ;                                 // Stores, jumps, illegal
        endcase
    end

    assign ctrl_xfer = op inside {OP_BEQ, OP_BNE, OP_J, OP_JR};

    // Next accepted instruction sits in the delay slot
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            delay_slot_q <= 1'b0;
        end else if (accept_i) begin
            delay_slot_q <= ctrl_xfer;
        end
    end

    always_comb begin
        bundle_o               = '0;
        bundle_o.valid         = fetch_i.valid;
        bundle_o.op            = op;
        bundle_o.pc            = fetch_i.pc;
        bundle_o.inst          = fetch_i.inst;
        bundle_o.rs            = fetch_i.inst[25:21];
        bundle_o.rt            = fetch_i.inst[20:16];
        bundle_o.sa            = fetch_i.inst[10:6];
        bundle_o.w_reg_ena     = w_ena;
        bundle_o.w_reg_dst     = w_dst;
        bundle_o.imme          = fetch_i.inst[15:0];
        bundle_o.j_imme        = fetch_i.inst[25:0];
        bundle_o.is_branch     = (op == OP_BEQ) || (op == OP_BNE);
        bundle_o.is_jr         = (op == OP_JR);
        bundle_o.is_j_imme     = (op == OP_J);
        bundle_o.is_ls         = (op == OP_LW) || (op == OP_SW);
        bundle_o.in_delay_slot = delay_slot_q;
        bundle_o.illegal       = (op == OP_ILLEGAL);
    end

endmodule

//--- design/id1_id2_reg.sv
module id1_id2_reg (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                stall_i,
    input  isa_pkg::id_bundle_t bundle_i,
    output isa_pkg::id_bundle_t bundle_o
);
    import isa_pkg::*;

    id_bundle_t bundle_q;

    // Flush beats stall
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            bundle_q <= '0;
        end else if (!stall_i) begin
            if (bundle_i.valid) begin
                bundle_q <= bundle_i;
            end else begin
                bundle_q <= '0;                        // Bubble
            end
        end
    end

    assign bundle_o = bundle_q;

endmodule

//--- design/issue_scoreboard.sv
`include "core_defines.svh"

module issue_scoreboard (
    input  logic                clk,
    input  logic                rst_n_i,
    input  isa_pkg::id_bundle_t bundle_i,
    input  logic                issue_fire_i,
    input  pipe_pkg::wb_t       wb_i,
    output logic                hazard_o
);
    import isa_pkg::*;

    logic [`REG_COUNT-1:0] pending_q;
    logic [`REG_COUNT-1:0] set_vec;
    logic [`REG_COUNT-1:0] clr_vec;
    logic                  reads_rs;
    logic                  reads_rt;
    logic                  rs_busy;
    logic                  rt_busy;

    always_comb begin
        set_vec = '0;
        clr_vec = '0;
        if (issue_fire_i && bundle_i.w_reg_ena && (bundle_i.w_reg_dst != '0)) begin
            set_vec[bundle_i.w_reg_dst] = 1'b1;
        end
        if (wb_i.valid) begin
            clr_vec[wb_i.reg_idx] = 1'b1;
        end
    end

    // Set wins over a same-edge writeback
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= ((pending_q & ~clr_vec) | set_vec) & ~`REG_COUNT'(1);
        end
    end

    always_comb begin
        reads_rs = 1'b0;
        reads_rt = 1'b0;
        case (bundle_i.op)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR,
            OP_BEQ, OP_BNE, OP_SW: begin
                reads_rs = 1'b1;
                reads_rt = 1'b1;
            end
            OP_SLL:                            reads_rt = 1'b1;
            OP_ADDIU, OP_ORI, OP_LW, OP_JR:    reads_rs = 1'b1;
            default: ;                                 // LUI, J, illegal
        endcase
    end

    assign rs_busy  = reads_rs && pending_q[bundle_i.rs];
    assign rt_busy  = reads_rt && pending_q[bundle_i.rt];
    assign hazard_o = bundle_i.valid && (rs_busy || rt_busy);

endmodule

//--- design/issue_csr.sv
`include "core_defines.svh"

module issue_csr (
    input  logic               clk,
    input  logic               rst_n_i,
    input  pipe_pkg::cfg_req_t cfg_i,
    output pipe_pkg::cfg_rsp_t cfg_o,
    input  logic               issue_fire_i,
    input  logic               hazard_stall_i,
    input  logic               flush_event_i,
    output logic               issue_en_o
);
    import pipe_pkg::*;

    logic               ack_q;
    logic               issue_en_q;
    logic [`DATA_W-1:0] issued_q;
    logic [`DATA_W-1:0] stalls_q;
    logic [`DATA_W-1:0] flushes_q;
    logic [`DATA_W-1:0] rdata_q;
    logic [`DATA_W-1:0] rd_word;
    logic               access;
    csr_addr_e          addr;

    function automatic logic [`DATA_W-1:0] sat_inc(input logic [`DATA_W-1:0] v);
        return (&v) ? v : v + 1'b1;
    endfunction

    assign access = cfg_i.req && !ack_q;               // New request not yet acked
    assign addr   = csr_addr_e'(cfg_i.addr);

    always_comb begin
        case (addr)
            CSR_CTRL:    rd_word = {{(`DATA_W-1){1'b0}}, issue_en_q};
            CSR_ISSUED:  rd_word = issued_q;
            CSR_STALLS:  rd_word = stalls_q;
            CSR_FLUSHES: rd_word = flushes_q;
            default:     rd_word = '0;
        endcase
    end

    // Four-phase slave with ack held until req drops
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            issue_en_q <= 1'b1;
        end else begin
            if (access) begin
                ack_q <= 1'b1;
                if (cfg_i.we && (addr == CSR_CTRL)) begin
                    issue_en_q <= cfg_i.wdata[0];
                end
            end else if (!cfg_i.req) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issued_q  <= '0;
            stalls_q  <= '0;
            flushes_q <= '0;
        end else begin
            if (issue_fire_i)   issued_q  <= sat_inc(issued_q);
            if (hazard_stall_i) stalls_q  <= sat_inc(stalls_q);
            if (flush_event_i)  flushes_q <= sat_inc(flushes_q);
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= rd_word;                        // Captured with the ack
        end
    end

    assign cfg_o.ack   = ack_q;
    assign cfg_o.rdata = rdata_q;
    assign issue_en_o  = issue_en_q;

endmodule

//--- design/decode_issue_top.sv
module decode_issue_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  pipe_pkg::fetch_t    fetch_i,
    output logic                fetch_ready_o,
    input  logic                flush_i,
    input  pipe_pkg::wb_t       wb_i,
    output isa_pkg::id_bundle_t issue_o,
    output logic                issue_valid_o,
    input  logic                issue_ready_i,
    input  pipe_pkg::cfg_req_t  cfg_i,
    output pipe_pkg::cfg_rsp_t  cfg_o
);
    import isa_pkg::*;

    id_bundle_t id1_bundle;
    id_bundle_t id2_bundle;
    logic       hazard;
    logic       issue_en;
    logic       stall;
    logic       accept;
    logic       issue_fire;

    // Single stall source for the register and fetch
    assign stall = id2_bundle.valid && (hazard || !issue_ready_i || !issue_en);

    assign fetch_ready_o = !stall;
    assign accept        = fetch_i.valid && fetch_ready_o;
    assign issue_valid_o = id2_bundle.valid && !hazard && issue_en;
    assign issue_fire    = issue_valid_o && issue_ready_i;
    assign issue_o       = id2_bundle;

    id1_decoder u_dec (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .fetch_i  (fetch_i),
        .accept_i (accept),
        .flush_i  (flush_i),
        .bundle_o (id1_bundle)
    );

    id1_id2_reg u_id2_reg (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .stall_i  (stall),
        .bundle_i (id1_bundle),
        .bundle_o (id2_bundle)
    );

    issue_scoreboard u_sb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .bundle_i     (id2_bundle),
        .issue_fire_i (issue_fire),
        .wb_i         (wb_i),
        .hazard_o     (hazard)
    );

    issue_csr u_csr (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .cfg_i          (cfg_i),
        .cfg_o          (cfg_o),
        .issue_fire_i   (issue_fire),
        .hazard_stall_i (id2_bundle.valid && hazard),
        .flush_event_i  (flush_i && id2_bundle.valid),
        .issue_en_o     (issue_en)
    );

endmodule

//--- test/tb_decode_issue.sv
`include "core_defines.svh"

module tb_decode_issue;
    timeunit 1ns;
    timeprecision 1ps;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int RAND_COUNT  = 40;                   // Random instructions per phase
    localparam int STIM_COUNT  = 2 * RAND_COUNT + 13;  // Plus directed sends and CSR accesses
    localparam int CYCLE_LIMIT = STIM_COUNT * 20 + 200;
    localparam logic [53:0] OPC_SET = {6'h00, 6'h02, 6'h04, 6'h05, 6'h09, 6'h0d, 6'h0f,
                                       6'h23, 6'h2b};
    localparam logic [35:0] FN_SET  = {6'h21, 6'h23, 6'h24, 6'h25, 6'h00, 6'h08};

    logic       clk;
    logic       rst_n_i;
    fetch_t     fetch_i;
    logic       fetch_ready_o;
    logic       flush_i;
    wb_t        wb_i;
    id_bundle_t issue_o;
    logic       issue_valid_o;
    logic       issue_ready_i;
    cfg_req_t   cfg_i;
    cfg_rsp_t   cfg_o;

    id_bundle_t            exp_q[$];                   // Accepted but not yet issued
    id_bundle_t            acc_bundle;
    id_bundle_t            held_bundle;
    logic [`REG_COUNT-1:0] pending;
    logic                  ds_model;
    logic                  en_model;
    logic                  auto_wb;
    logic                  toggle_ready;
    logic                  held;                       // Offered last cycle and refused
    logic                  busy;
    logic                  hz;
    logic                  fire;
    logic [31:0]           pc;
    int                    n_issued;
    int                    n_stalls;
    int                    n_flushes;
    int                    val_errs;
    int                    flow_errs;
    int                    cycles = 0;

    decode_issue_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles with tests still running", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    function automatic id_bundle_t ref_decode(input logic [31:0] pc_v, input logic [31:0] inst,
                                              input logic ds);
        id_bundle_t b;
        b               = '0;
        b.valid         = 1'b1;
        b.pc            = pc_v;
        b.inst          = inst;
        b.rs            = inst[25:21];
        b.rt            = inst[20:16];
        b.sa            = inst[10:6];
        b.imme          = inst[15:0];
        b.j_imme        = inst[25:0];
        b.in_delay_slot = ds;
        case (inst[31:26])
            6'h00: case (inst[5:0])
                6'h21:   b.op = OP_ADDU;
                6'h23:   b.op = OP_SUBU;
                6'h24:   b.op = OP_AND;
                6'h25:   b.op = OP_OR;
                6'h00:   b.op = OP_SLL;
                6'h08:   b.op = OP_JR;
                default: b.op = OP_ILLEGAL;
            endcase
            6'h02:   b.op = OP_J;
            6'h04:   b.op = OP_BEQ;
            6'h05:   b.op = OP_BNE;
            6'h09:   b.op = OP_ADDIU;
            6'h0d:   b.op = OP_ORI;
            6'h0f:   b.op = OP_LUI;
            6'h23:   b.op = OP_LW;
            6'h2b:   b.op = OP_SW;
            default: b.op = OP_ILLEGAL;
        endcase
        b.w_reg_ena = b.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLL,
                                   OP_ADDIU, OP_ORI, OP_LUI, OP_LW};
        b.w_reg_dst = !b.w_reg_ena ? 5'd0 : (inst[31:26] == 6'h00) ? inst[15:11] : inst[20:16];
        b.is_branch = b.op inside {OP_BEQ, OP_BNE};
        b.is_jr     = (b.op == OP_JR);
        b.is_j_imme = (b.op == OP_J);
        b.is_ls     = b.op inside {OP_LW, OP_SW};
        b.illegal   = (b.op == OP_ILLEGAL);
        return b;
    endfunction

    // Mostly legal encodings plus some random opcodes and functs
    function automatic logic [31:0] rand_inst();
        logic [31:0] inst;
        int          k;
        inst = $urandom;
        k    = $urandom % 10;
        if (k < 9) begin
            inst[31:26] = OPC_SET[k*6 +: 6];
        end
        if (inst[31:26] == 6'h00 && ($urandom % 8) != 0) begin
            inst[5:0] = FN_SET[($urandom % 6) * 6 +: 6];
        end
        return inst;
    endfunction

    function automatic logic model_hazard(input id_bundle_t b);
        logic rs_rd;
        logic rt_rd;
        rs_rd = b.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_BEQ, OP_BNE, OP_SW,
                             OP_ADDIU, OP_ORI, OP_LW, OP_JR};
        rt_rd = b.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_BEQ, OP_BNE, OP_SW, OP_SLL};
        return b.valid && ((rs_rd && pending[b.rs]) || (rt_rd && pending[b.rt]));
    endfunction

    task automatic check_bundle(input id_bundle_t got, input id_bundle_t exp, input string what);
        if (got !== exp) begin
            val_errs++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            val_errs++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            val_errs++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Compare process sees each edge's inputs half a cycle early
    always @(negedge clk) begin
        if (rst_n_i) begin
            busy = exp_q.size() > 0;
            hz   = busy && model_hazard(exp_q[0]);
            fire = issue_valid_o && issue_ready_i;
            check_bit(issue_valid_o, busy && !hz && en_model, "issue_valid_o");
            check_bit(fetch_ready_o, !(busy && (hz || !issue_ready_i || !en_model)),
                      "fetch_ready_o");
            if (held) begin
                check_bundle(issue_o, held_bundle, "issue_o under back-pressure");
            end
            held        = issue_valid_o && !issue_ready_i && !flush_i;
            held_bundle = issue_o;
            if (hz) begin
                n_stalls++;
            end
            if (flush_i && busy) begin
                n_flushes++;
            end
            if (wb_i.valid) begin
                pending[wb_i.reg_idx] = 1'b0;
            end
            if (fire) begin
                n_issued++;
                if (!busy) begin
                    flow_errs++;
                    $display("Instruction issued at %0t with none accepted and waiting", $time);
                end else begin
                    check_bundle(issue_o, exp_q[0], "issued bundle");
                    if (exp_q[0].w_reg_ena && exp_q[0].w_reg_dst != 5'd0) begin
                        pending[exp_q[0].w_reg_dst] = 1'b1;   // Set after clear
                    end
                    void'(exp_q.pop_front());
                end
            end
            if (flush_i) begin
                exp_q.delete();
                ds_model = 1'b0;
            end else if (fetch_i.valid && fetch_ready_o) begin
                acc_bundle = ref_decode(fetch_i.pc, fetch_i.inst, ds_model);
                exp_q.push_back(acc_bundle);
                ds_model = acc_bundle.is_branch || acc_bundle.is_jr || acc_bundle.is_j_imme;
            end
            if (cfg_i.req && !cfg_o.ack && cfg_i.we && cfg_i.addr == CSR_CTRL) begin
                en_model = cfg_i.wdata[0];
            end
        end
    end

    // Back-pressure and writeback sources
    always @(posedge clk) begin
        if (toggle_ready) begin
            issue_ready_i <= 1'($urandom % 2);
        end
        if (auto_wb) begin
            wb_i <= '0;
            if (pending != '0 && ($urandom % 2) != 0) begin
                for (int r = `REG_COUNT - 1; r > 0; r--) begin
                    if (pending[r]) begin
                        wb_i <= {1'b1, 5'(r)};         // Lowest pending wins
                    end
                end
            end
        end
    end

    task automatic send(input logic [31:0] inst);
        fetch_i <= {1'b1, pc, inst};
        pc = pc + 32'd4;
        @(negedge clk);
        while (!fetch_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        fetch_i.valid <= 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic cfg_access(input logic we, input csr_addr_e addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        cfg_i <= {1'b1, we, addr, wdata};
        @(negedge clk);
        check_bit(cfg_o.ack, 1'b0, "ack before req is seen");
        @(negedge clk);
        check_bit(cfg_o.ack, 1'b1, "ack one edge after req");
        rdata = cfg_o.rdata;
        @(posedge clk);
        cfg_i.req <= 1'b0;
        @(negedge clk);
        check_bit(cfg_o.ack, 1'b1, "ack held until req low is seen");
        @(negedge clk);
        check_bit(cfg_o.ack, 1'b0, "ack after req low");
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] rd;
        rd            = $urandom(94);
        rst_n_i       = 1'b0;
        fetch_i       = '0;
        flush_i       = 1'b0;
        wb_i          = '0;
        issue_ready_i = 1'b1;
        cfg_i         = '0;
        pending       = '0;
        ds_model      = 1'b0;
        en_model      = 1'b1;
        auto_wb       = 1'b1;
        toggle_ready  = 1'b0;
        held          = 1'b0;
        pc            = 32'h0000_1000;
        n_issued      = 0;
        n_stalls      = 0;
        n_flushes     = 0;
        val_errs      = 0;
        flow_errs     = 0;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        repeat (RAND_COUNT) send(rand_inst());
        drain();

        toggle_ready = 1'b1;
        repeat (RAND_COUNT) send(rand_inst());
        drain();
        toggle_ready = 1'b0;
        issue_ready_i <= 1'b1;

        // Let leftover writes from the random phases retire
        while (pending != '0) begin
            @(posedge clk);
        end
        auto_wb = 1'b0;
        wb_i <= '0;
        send(32'h2405_0007);                           // r5 = r0 + 7
        send(32'h00a0_3021);                           // r6 = r5 + r0 waits on r5
        repeat (6) @(posedge clk);
        wb_i <= {1'b1, 5'd5};
        @(posedge clk);
        wb_i <= '0;
        drain();
        send(32'h0022_0021);                           // Write to r0
        send(32'h0000_1821);                           // Reads r0 only
        drain();
        auto_wb = 1'b1;

        issue_ready_i <= 1'b0;
        send(32'h1000_0003);                           // beq r0, r0
        repeat (3) @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        issue_ready_i <= 1'b1;
        send(32'h3421_00ff);                           // Delay slot cleared by flush
        drain();

        cfg_access(1'b1, CSR_CTRL, 32'h0, rd);
        send(32'h2402_0001);
        repeat (5) @(posedge clk);
        cfg_access(1'b0, CSR_CTRL, 32'h0, rd);
        check_word(rd, 32'h0, "CSR_CTRL after clear");
        cfg_access(1'b1, CSR_CTRL, 32'h1, rd);
        drain();
        cfg_access(1'b0, CSR_ISSUED, 32'h0, rd);
        check_word(rd, n_issued, "CSR_ISSUED");
        cfg_access(1'b0, CSR_STALLS, 32'h0, rd);
        check_word(rd, n_stalls, "CSR_STALLS");
        cfg_access(1'b0, CSR_FLUSHES, 32'h0, rd);
        check_word(rd, n_flushes, "CSR_FLUSHES");

        $display("Run complete with %0d value errors and %0d other errors", val_errs, flow_errs);
        if (val_errs + flow_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- decode_issue_top.f
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/id1_decoder.sv
design/id1_id2_reg.sv
design/issue_scoreboard.sv
design/issue_csr.sv
design/decode_issue_top.sv
test/tb_decode_issue.sv

//--- Bender.yml
package:
  name: decode_issue

sources:
  - include_dirs:
      - design
    files:
      - design/isa_pkg.sv
      - design/pipe_pkg.sv
      - design/id1_decoder.sv
      - design/id1_id2_reg.sv
      - design/issue_scoreboard.sv
      - design/issue_csr.sv
      - design/decode_issue_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_decode_issue.sv
